//--- src/rvfi_monitor_pkg.sv
package rvfi_monitor_pkg;

    typedef logic [31:0] xlen_t;      // pc, data and address values
    typedef logic [31:0] insn_t;
    typedef logic [63:0] order_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mem_mask_t;  // one bit per byte lane
    typedef logic [63:0] cycle_t;

    // one retirement as seen on the RVFI port, plus its cycle stamp
    typedef struct packed {
        order_t    order;
        insn_t     insn;
        logic      trap;
        logic      halt;
        logic      intr;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        xlen_t     rs1_rdata;
        xlen_t     rs2_rdata;
        xlen_t     rd_wdata;
        xlen_t     pc_rdata;
        xlen_t     pc_wdata;
        xlen_t     mem_addr;
        mem_mask_t mem_rmask;
        mem_mask_t mem_wmask;
        xlen_t     mem_rdata;
        xlen_t     mem_wdata;
        cycle_t    cycle;
    } rvfi_trace_t;

    typedef enum logic [1:0] {
        chk_idle,    // nothing retired since reset
        chk_run,     // previous record held for comparison
        chk_halted   // a halt has retired
    } chk_state_t;

    typedef enum logic [2:0] {
        stat_retired,
        stat_traps,
        stat_loads,
        stat_stores,
        stat_jumps,
        stat_cycles,
        stat_errors
    } stat_sel_t;

endpackage

//--- src/rvfi_retire_if.sv
interface rvfi_retire_if import rvfi_monitor_pkg::*; ();

    // one record per cycle with valid high; the core is never stalled,
    // so there is no ready in the other direction

    logic        valid;  // single-cycle strobe
    rvfi_trace_t trace;  // only meaningful while valid is high
    logic        first;  // set on the first record after reset

    modport src (
        output valid,
        output trace,
        output first
    );

    modport snk (
        input valid,
        input trace,
        input first
    );

endinterface

//--- src/rvfi_capture.sv
module rvfi_capture import rvfi_monitor_pkg::*; (
    input  logic       rvfi_ext_clk,
    input  logic       rvfi_ext_reset_n,

    input  logic       rvfi_valid,
    input  order_t     rvfi_order,
    input  insn_t      rvfi_insn,
    input  logic       rvfi_trap,
    input  logic       rvfi_halt,
    input  logic       rvfi_intr,
    input  reg_addr_t  rvfi_rs1_addr,
    input  reg_addr_t  rvfi_rs2_addr,
    input  xlen_t      rvfi_rs1_rdata,
    input  xlen_t      rvfi_rs2_rdata,
    input  reg_addr_t  rvfi_rd_addr,
    input  xlen_t      rvfi_rd_wdata,
    input  xlen_t      rvfi_pc_rdata,
    input  xlen_t      rvfi_pc_wdata,
    input  xlen_t      rvfi_mem_addr,
    input  mem_mask_t  rvfi_mem_rmask,
    input  mem_mask_t  rvfi_mem_wmask,
    input  xlen_t      rvfi_mem_rdata,
    input  xlen_t      rvfi_mem_wdata,

    rvfi_retire_if.src retire
);

    cycle_t cycle_counter;
    logic   seen;           // a record has been captured since reset

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            cycle_counter <= '0;
            seen          <= 1'b0;
            retire.valid  <= 1'b0;
            retire.first  <= 1'b0;
        end else begin
            cycle_counter <= cycle_counter + 64'd1;
            retire.valid  <= rvfi_valid;
            if (rvfi_valid) begin
                retire.first <= !seen;
                seen         <= 1'b1;
            end
        end
    end

    always_ff @(posedge rvfi_ext_clk) begin
        if (rvfi_valid) begin
            retire.trace <= '{
                order:     rvfi_order,
                insn:      rvfi_insn,
                trap:      rvfi_trap,
                halt:      rvfi_halt,
                intr:      rvfi_intr,
                rs1_addr:  rvfi_rs1_addr,
                rs2_addr:  rvfi_rs2_addr,
                rd_addr:   rvfi_rd_addr,
                rs1_rdata: rvfi_rs1_rdata,
                rs2_rdata: rvfi_rs2_rdata,
                rd_wdata:  rvfi_rd_wdata,
                pc_rdata:  rvfi_pc_rdata,
                pc_wdata:  rvfi_pc_wdata,
                mem_addr:  rvfi_mem_addr,
                mem_rmask: rvfi_mem_rmask,
                mem_wmask: rvfi_mem_wmask,
                mem_rdata: rvfi_mem_rdata,
                mem_wdata: rvfi_mem_wdata,
                cycle:     cycle_counter
            };
        end
    end

endmodule

//--- src/rvfi_checker.sv
module rvfi_checker import rvfi_monitor_pkg::*; (
    input  logic       rvfi_ext_clk,
    input  logic       rvfi_ext_reset_n,

    rvfi_retire_if.snk retire,

    output logic [3:0] err_flags,   // [0] order, [1] pc, [2] x0, [3] mask
    output cycle_t     err_count,
    output logic       halted
);

    chk_state_t  state;
    logic [31:0] prev_order;        // low half of the order is enough to see a skip
    xlen_t       prev_pc;
    logic        has_prev;
    logic [3:0]  rec_err;

    // legal masks are none, a single byte, an aligned halfword or the whole word
    function automatic logic mask_ok(input mem_mask_t mask);
        case (mask)
            4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b1100, 4'b1111: return 1'b1;
            default:                   return 1'b0;
        endcase
    endfunction

    assign has_prev = (state == chk_run) && !retire.first;
    assign halted   = (state == chk_halted);

    // ##########################################################
    // per-record checks
    // ##########################################################

    always_comb begin
        rec_err = '0;
        if (retire.valid) begin
            rec_err[0] = halted ||
                         (has_prev && (retire.trace.order[31:0] != prev_order + 32'd1));
            rec_err[1] = has_prev && !retire.trace.intr &&
                         (retire.trace.pc_rdata != prev_pc);
            rec_err[2] = (retire.trace.rd_addr == '0) && (retire.trace.rd_wdata != '0);
            rec_err[3] = !mask_ok(retire.trace.mem_rmask) ||
                         !mask_ok(retire.trace.mem_wmask);
        end
    end

    // ##########################################################
    // state and sticky error flags
    // ##########################################################

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            state     <= chk_idle;
            err_flags <= '0;
            err_count <= '0;
        end else if (retire.valid) begin
            err_flags <= err_flags | rec_err;
            if (|rec_err) begin
                err_count <= err_count + 64'd1;  // one count per bad record
            end
            case (state)
                chk_idle,
                chk_run:    state <= retire.trace.halt ? chk_halted : chk_run;
                default:    state <= chk_halted;
            endcase
        end
    end

    always_ff @(posedge rvfi_ext_clk) begin
        if (retire.valid) begin
            prev_order <= retire.trace.order[31:0];
            prev_pc    <= retire.trace.pc_wdata;
        end
    end

endmodule

//--- src/rvfi_profiler.sv
module rvfi_profiler import rvfi_monitor_pkg::*; #(
    parameter int STAT_WIDTH = 32
) (
    input  logic                  rvfi_ext_clk,
    input  logic                  rvfi_ext_reset_n,

    rvfi_retire_if.snk            retire,

    output logic [STAT_WIDTH-1:0] cnt_retired,
    output logic [STAT_WIDTH-1:0] cnt_traps,
    output logic [STAT_WIDTH-1:0] cnt_loads,
    output logic [STAT_WIDTH-1:0] cnt_stores,
    output logic [STAT_WIDTH-1:0] cnt_jumps,
    output logic [STAT_WIDTH-1:0] cnt_cycles
);

    typedef logic [STAT_WIDTH-1:0] stat_t;

    logic is_load;
    logic is_store;
    logic is_jump;

    // counters stick at all ones instead of wrapping
    function automatic stat_t sat_inc(input stat_t value, input logic en);
        if (en && !(&value)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    assign is_load  = retire.valid && (retire.trace.mem_rmask != '0);
    assign is_store = retire.valid && (retire.trace.mem_wmask != '0);
    assign is_jump  = retire.valid &&
                      (retire.trace.pc_wdata != retire.trace.pc_rdata + 32'd4);

    // ##########################################################
    // category counters
    // ##########################################################

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            cnt_retired <= '0;
            cnt_traps   <= '0;
            cnt_loads   <= '0;
            cnt_stores  <= '0;
            cnt_jumps   <= '0;
            cnt_cycles  <= '0;
        end else begin
            cnt_cycles  <= sat_inc(cnt_cycles, 1'b1);
            cnt_retired <= sat_inc(cnt_retired, retire.valid);
            cnt_traps   <= sat_inc(cnt_traps, retire.valid && retire.trace.trap);
            cnt_loads   <= sat_inc(cnt_loads, is_load);
            cnt_stores  <= sat_inc(cnt_stores, is_store);
            cnt_jumps   <= sat_inc(cnt_jumps, is_jump);  // taken branches count too
        end
    end

endmodule

//--- src/rvfi_report.sv
module rvfi_report import rvfi_monitor_pkg::*; #(
    parameter int STAT_WIDTH = 32
) (
    input  logic                  rvfi_ext_clk,
    input  logic                  rvfi_ext_reset_n,

    input  stat_sel_t             stat_sel,

    input  logic [STAT_WIDTH-1:0] cnt_retired,
    input  logic [STAT_WIDTH-1:0] cnt_traps,
    input  logic [STAT_WIDTH-1:0] cnt_loads,
    input  logic [STAT_WIDTH-1:0] cnt_stores,
    input  logic [STAT_WIDTH-1:0] cnt_jumps,
    input  logic [STAT_WIDTH-1:0] cnt_cycles,
    input  cycle_t                err_count,
    input  logic [3:0]            err_flags_in,

    output logic [STAT_WIDTH-1:0] stat_value,
    output logic [3:0]            err_flags,
    output logic                  err_any
);

    logic [STAT_WIDTH-1:0] stat_next;

    always_comb begin
        case (stat_sel)
            stat_retired: stat_next = cnt_retired;
            stat_traps:   stat_next = cnt_traps;
            stat_loads:   stat_next = cnt_loads;
            stat_stores:  stat_next = cnt_stores;
            stat_jumps:   stat_next = cnt_jumps;
            stat_cycles:  stat_next = cnt_cycles;
            stat_errors:  stat_next = err_count[STAT_WIDTH-1:0];  // low bits only
            default:      stat_next = '0;
        endcase
    end

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            stat_value <= '0;
            err_flags  <= '0;
            err_any    <= 1'b0;
        end else begin
            stat_value <= stat_next;
            err_flags  <= err_flags_in;
            err_any    <= |err_flags_in;  // stays in step with err_flags
        end
    end

endmodule

//--- src/rvfi_ext_monitor.sv
module rvfi_ext_monitor import rvfi_monitor_pkg::*; #(
    parameter int STAT_WIDTH = 32
) (
    input  logic                  rvfi_ext_clk,
    input  logic                  rvfi_ext_reset_n,

    input  logic                  rvfi_valid,
    input  order_t                rvfi_order,
    input  insn_t                 rvfi_insn,
    input  logic                  rvfi_trap,
    input  logic                  rvfi_halt,
    input  logic                  rvfi_intr,
    input  logic [1:0]            rvfi_mode,  // accepted, not monitored
    input  logic [1:0]            rvfi_ixl,   // accepted, not monitored
    input  reg_addr_t             rvfi_rs1_addr,
    input  reg_addr_t             rvfi_rs2_addr,
    input  xlen_t                 rvfi_rs1_rdata,
    input  xlen_t                 rvfi_rs2_rdata,
    input  reg_addr_t             rvfi_rd_addr,
    input  xlen_t                 rvfi_rd_wdata,
    input  xlen_t                 rvfi_pc_rdata,
    input  xlen_t                 rvfi_pc_wdata,
    input  xlen_t                 rvfi_mem_addr,
    input  mem_mask_t             rvfi_mem_rmask,
    input  mem_mask_t             rvfi_mem_wmask,
    input  xlen_t                 rvfi_mem_rdata,
    input  xlen_t                 rvfi_mem_wdata,

    input  stat_sel_t             stat_sel,
    output logic [STAT_WIDTH-1:0] stat_value,
    output logic [3:0]            err_flags,
    output logic                  err_any,
    output logic                  halted
);

    logic [3:0]            chk_err_flags;
    cycle_t                err_count;
    logic [STAT_WIDTH-1:0] cnt_retired;
    logic [STAT_WIDTH-1:0] cnt_traps;
    logic [STAT_WIDTH-1:0] cnt_loads;
    logic [STAT_WIDTH-1:0] cnt_stores;
    logic [STAT_WIDTH-1:0] cnt_jumps;
    logic [STAT_WIDTH-1:0] cnt_cycles;

    rvfi_retire_if u_retire_if ();

    // ##########################################################
    // capture, then check and profile side by side
    // ##########################################################

    rvfi_capture u_capture (
        .rvfi_ext_clk, .rvfi_ext_reset_n,
        .rvfi_valid, .rvfi_order, .rvfi_insn, .rvfi_trap, .rvfi_halt, .rvfi_intr,
        .rvfi_rs1_addr, .rvfi_rs2_addr, .rvfi_rs1_rdata, .rvfi_rs2_rdata,
        .rvfi_rd_addr, .rvfi_rd_wdata, .rvfi_pc_rdata, .rvfi_pc_wdata,
        .rvfi_mem_addr, .rvfi_mem_rmask, .rvfi_mem_wmask,
        .rvfi_mem_rdata, .rvfi_mem_wdata,
        .retire (u_retire_if.src)
    );

    rvfi_checker u_checker (
        .rvfi_ext_clk, .rvfi_ext_reset_n,
        .retire    (u_retire_if.snk),
        .err_flags (chk_err_flags),
        .err_count (err_count),
        .halted    (halted)
    );

    rvfi_profiler #(.STAT_WIDTH(STAT_WIDTH)) u_profiler (
        .rvfi_ext_clk, .rvfi_ext_reset_n,
        .retire (u_retire_if.snk),
        .cnt_retired, .cnt_traps, .cnt_loads, .cnt_stores, .cnt_jumps, .cnt_cycles
    );

    rvfi_report #(.STAT_WIDTH(STAT_WIDTH)) u_report (
        .rvfi_ext_clk, .rvfi_ext_reset_n,
        .stat_sel,
        .cnt_retired, .cnt_traps, .cnt_loads, .cnt_stores, .cnt_jumps, .cnt_cycles,
        .err_count,
        .err_flags_in (chk_err_flags),
        .stat_value, .err_flags, .err_any
    );

endmodule

//--- verif/rvfi_ext_monitor_asserts.sv
module rvfi_ext_monitor_asserts import rvfi_monitor_pkg::*; #(
    parameter int STAT_WIDTH = 32
) (
    input logic                  rvfi_ext_clk,
    input logic                  rvfi_ext_reset_n,
    input logic                  rvfi_valid,
    input logic                  retire_valid,
    input chk_state_t            chk_state,
    input logic [3:0]            chk_err_flags,
    input logic [3:0]            err_flags,
    input logic                  err_any,
    input logic                  halted,
    input logic [STAT_WIDTH-1:0] stat_value
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // the testbench watches this

    // ##########################################################
    // pipeline timing and reset values
    // ##########################################################

    a_retire_latency: assert property (@(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        retire_valid == $past(rvfi_valid))
        else begin
            fail_count++;
            $error("retire valid did not follow rvfi_valid by exactly one edge");
        end

    a_reset_quiet: assert property (@(posedge rvfi_ext_clk)
        !rvfi_ext_reset_n |=> (stat_value == '0) && (err_flags == '0) && !err_any &&
                              !halted && !retire_valid)
        else begin
            fail_count++;
            $error("an output was not zero during reset or just after it");
        end

    // ##########################################################
    // error flags and halt state
    // ##########################################################

    a_err_any_or: assert property (@(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        $changed(chk_err_flags) |=> (err_flags == $past(chk_err_flags)) &&
                                    (err_any == |$past(chk_err_flags)))
        else begin
            fail_count++;
            $error("err_flags or err_any did not follow the checker flags");
        end

    a_halt_sticky: assert property (@(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        (chk_state == chk_halted) |=> (chk_state == chk_halted) && halted && !$fell(halted))
        else begin
            fail_count++;
            $error("halted fell while reset was not asserted");
        end

endmodule

bind rvfi_ext_monitor rvfi_ext_monitor_asserts #(.STAT_WIDTH(STAT_WIDTH)) u_asserts (
    .rvfi_ext_clk,
    .rvfi_ext_reset_n,
    .rvfi_valid,
    .retire_valid  (u_retire_if.valid),
    .chk_state     (u_checker.state),
    .chk_err_flags (chk_err_flags),
    .err_flags,
    .err_any,
    .halted,
    .stat_value
);

//--- verif/rvfi_ext_monitor_tb.sv
module rvfi_ext_monitor_tb import rvfi_monitor_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STAT_WIDTH = 32;
    localparam int max_cycles = 3000;  // well above the longest possible run of all phases

    logic                  rvfi_ext_clk, rvfi_ext_reset_n;
    logic                  rvfi_valid, rvfi_trap, rvfi_halt, rvfi_intr;
    logic [1:0]            rvfi_mode, rvfi_ixl;
    order_t                rvfi_order;
    insn_t                 rvfi_insn;
    reg_addr_t             rvfi_rs1_addr, rvfi_rs2_addr, rvfi_rd_addr;
    xlen_t                 rvfi_rs1_rdata, rvfi_rs2_rdata, rvfi_rd_wdata;
    xlen_t                 rvfi_pc_rdata, rvfi_pc_wdata, rvfi_mem_addr;
    xlen_t                 rvfi_mem_rdata, rvfi_mem_wdata;
    mem_mask_t             rvfi_mem_rmask, rvfi_mem_wmask;
    stat_sel_t             stat_sel;
    logic [STAT_WIDTH-1:0] stat_value;
    logic [3:0]            err_flags;
    logic                  err_any, halted;

    order_t     next_order;  // reference model of the retirement stream
    xlen_t      next_pc;
    int         exp_retired, exp_traps, exp_loads, exp_stores, exp_jumps, exp_errors;
    logic [3:0] exp_flags;
    int         cycle_count = 0;

    rvfi_ext_monitor #(.STAT_WIDTH(STAT_WIDTH)) u_rvfi_ext_monitor (.*);

    always #20 rvfi_ext_clk = ~rvfi_ext_clk;

    always @(negedge rvfi_ext_clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end else if (u_rvfi_ext_monitor.u_asserts.fail_count != 0) begin
            $display("A timing assertion on the monitor failed at %0t ns", $time);
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end else if (err_any && (exp_flags == '0)) begin
            $display("Mismatch at %0t ns: err_any is set before any fault was injected", $time);
            $display("Result: FAILED");
            $fatal(1, "early error");
        end
    end

    function automatic mem_mask_t legal_mask();
        case ($urandom % 7)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            3:       return 4'b1000;
            4:       return 4'b0011;
            5:       return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [63:0] expected_stat(input stat_sel_t sel);
        case (sel)
            stat_retired: return 64'(exp_retired);
            stat_traps:   return 64'(exp_traps);
            stat_loads:   return 64'(exp_loads);
            stat_stores:  return 64'(exp_stores);
            stat_jumps:   return 64'(exp_jumps);
            default:      return 64'(exp_errors);
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ##########################################################
    // stimulus
    // ##########################################################

    // sets up a legal record that continues the stream, as a plain op, load, store or jump
    task automatic build_record();
        int kind;
        kind           = $urandom % 4;
        rvfi_order     = next_order;
        rvfi_insn      = $urandom;
        {rvfi_trap, rvfi_halt, rvfi_intr} = 3'b000;
        rvfi_rs1_addr  = 5'($urandom);
        rvfi_rs2_addr  = 5'($urandom);
        rvfi_rd_addr   = 5'($urandom);
        rvfi_rs1_rdata = $urandom;
        rvfi_rs2_rdata = $urandom;
        rvfi_rd_wdata  = (rvfi_rd_addr == '0) ? '0 : $urandom;
        rvfi_pc_rdata  = next_pc;
        rvfi_pc_wdata  = next_pc + 32'd4;
        rvfi_mem_addr  = $urandom;
        rvfi_mem_rmask = '0;
        rvfi_mem_wmask = '0;
        rvfi_mem_rdata = $urandom;
        rvfi_mem_wdata = $urandom;
        case (kind)
            1:       rvfi_mem_rmask = legal_mask();
            2:       rvfi_mem_wmask = legal_mask();
            3:       rvfi_pc_wdata = next_pc + 32'((($urandom % 64) + 2) * 4);
            default: ;
        endcase
    endtask

    task automatic retire_record();
        rvfi_valid = 1'b1;
        exp_retired++;
        if (rvfi_trap) exp_traps++;
        if (rvfi_mem_rmask != '0) exp_loads++;
        if (rvfi_mem_wmask != '0) exp_stores++;
        if (rvfi_pc_wdata != rvfi_pc_rdata + 32'd4) exp_jumps++;
        next_order = rvfi_order + 64'd1;
        next_pc    = rvfi_pc_wdata;
        @(negedge rvfi_ext_clk);
        rvfi_valid = 1'b0;
    endtask

    task automatic check_stats();
        repeat (4) @(negedge rvfi_ext_clk);  // last record reaches stat_value after three edges
        for (int i = 0; i < 7; i++) begin
            if (stat_sel_t'(i) != stat_cycles) begin
                stat_sel = stat_sel_t'(i);
                @(negedge rvfi_ext_clk);
                check_value(stat_sel.name(), stat_value, expected_stat(stat_sel));
            end
        end
        check_value("err_flags", err_flags, exp_flags);
    endtask

    task automatic check_cycle_delta();
        logic [STAT_WIDTH-1:0] first_read;
        int                    gap;
        gap      = 10 + ($urandom % 40);
        stat_sel = stat_cycles;
        @(negedge rvfi_ext_clk);
        first_read = stat_value;
        repeat (gap) @(negedge rvfi_ext_clk);
        check_value("stat_cycles delta", stat_value - first_read, gap);
    endtask

    // bit_idx follows err_flags: order, pc, x0, mask
    task automatic inject_fault(input int bit_idx);
        build_record();
        case (bit_idx)
            0:       rvfi_order = next_order + 64'd1;
            1:       rvfi_pc_rdata = next_pc + 32'd64;
            2: begin
                rvfi_rd_addr  = '0;
                rvfi_rd_wdata = $urandom | 32'd1;
            end
            default: rvfi_mem_wmask = 4'b0110;
        endcase
        retire_record();
        exp_errors++;
        exp_flags[bit_idx] = 1'b1;
        repeat (4) @(negedge rvfi_ext_clk);
        check_value("err_flags", err_flags, exp_flags);
    endtask

    initial begin
        void'($urandom(32'hb51e_ce61));
        {rvfi_ext_clk, rvfi_ext_reset_n, rvfi_valid} = 3'b000;
        {rvfi_mode, rvfi_ixl} = 4'b0;
        stat_sel   = stat_retired;
        next_order = '0;
        next_pc    = 32'h0000_1000;
        {exp_retired, exp_traps, exp_loads, exp_stores, exp_jumps, exp_errors} = '0;
        exp_flags  = '0;
        build_record();
        repeat (8) @(negedge rvfi_ext_clk);
        rvfi_ext_reset_n = 1'b1;
        @(negedge rvfi_ext_clk);

        for (int i = 0; i < 200; i++) begin
            build_record();
            retire_record();
            repeat ($urandom % 3) @(negedge rvfi_ext_clk);  // zero gives back-to-back records
        end
        check_stats();
        check_cycle_delta();

        for (int i = 0; i < 20; i++) begin
            build_record();
            rvfi_trap = (i % 5 == 0);
            if (i == 10) begin
                rvfi_intr     = 1'b1;  // an interrupt may legally redirect the pc
                rvfi_pc_rdata = next_pc + 32'h200;
                rvfi_pc_wdata = rvfi_pc_rdata + 32'd4;
            end
            retire_record();
        end
        check_stats();

        for (int f = 0; f < 4; f++) begin
            inject_fault(f);
        end
        check_stats();

        build_record();
        rvfi_halt = 1'b1;
        retire_record();
        repeat (4) @(negedge rvfi_ext_clk);
        check_value("halted", halted, 64'd1);
        build_record();
        retire_record();
        exp_errors++;  // nothing may retire after a halt
        check_stats();

        repeat (4) @(negedge rvfi_ext_clk);
        if (u_rvfi_ext_monitor.u_asserts.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

//--- rvfi_ext_monitor.f
src/rvfi_monitor_pkg.sv
src/rvfi_retire_if.sv
src/rvfi_capture.sv
src/rvfi_checker.sv
src/rvfi_profiler.sv
src/rvfi_report.sv
src/rvfi_ext_monitor.sv
verif/rvfi_ext_monitor_asserts.sv
verif/rvfi_ext_monitor_tb.sv
